// File: filelist.f
verilog/mm_data_pkg.sv
verilog/mm_ctrl_pkg.sv
verilog/mm_loader.sv
verilog/mm_rotate_store.sv
verilog/mm_mac_array.sv
verilog/mm_ctrl.sv
verilog/mm_drain.sv
verilog/mm_top.sv
test/mm_assert.sv
test/tb_mm.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mm -f filelist.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mm 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi

echo "run_sim: pass message not found in the simulation output"
exit 1

// File: test/mm_assert.sv
`timescale 1ns/1ps

module mm_assert (
    input logic                  axis_clk,
    input logic                  axis_rst_n,
    input logic                  ss_tready,
    input logic                  sm_tvalid,
    input logic                  sm_tready,
    input mm_data_pkg::mm_word_t sm_tdata
);

    // load and drain never overlap
    a_no_overlap: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid))
        else $error("ss_tready and sm_tvalid high in the same cycle");

    a_data_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> $stable(sm_tdata))
        else $error("sm_tdata changed while the output beat was stalled");

    a_valid_held: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> sm_tvalid)
        else $error("sm_tvalid dropped before the output beat was accepted");

endmodule

bind mm_top mm_assert u_assert (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata)
);

// File: test/tb_mm.sv
`timescale 1ns/1ps

module tb_mm;
    import mm_data_pkg::*;

    typedef mm_word_t [MM_DIM*MM_DIM-1:0] mat_t;

    localparam int JOB_CYCLES     = 32 * 4 + 16 + 16 * 4;
    localparam int TIMEOUT_CYCLES = 6 * JOB_CYCLES + 200;

    logic     axis_clk;
    logic     axis_rst_n;
    logic     ss_tvalid;
    logic     ss_tready;
    mm_word_t ss_tdata;
    logic     sm_tvalid;
    logic     sm_tready;
    mm_word_t sm_tdata;

    logic [31:0] rnd_state;
    logic [31:0] rdy_state;
    logic        gaps_on;
    logic        stall_on;
    mm_word_t    exp_q [$];
    mm_word_t    exp_word;
    int          in_beats;
    int          out_beats;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          cycles;

    mm_top uut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata)
    );

    always #2 axis_clk = ~axis_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // C = A * B, every sum wraps at 32 bits
    function automatic mat_t matmul_ref(input mat_t a, input mat_t b);
        mat_t     c;
        mm_word_t acc;
        for (int r = 0; r < MM_DIM; r++) begin
            for (int col = 0; col < MM_DIM; col++) begin
                acc = '0;
                for (int m = 0; m < MM_DIM; m++) begin
                    acc = acc + a[r*MM_DIM+m] * b[m*MM_DIM+col];
                end
                c[r*MM_DIM+col] = acc;
            end
        end
        return c;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic fill_random(output mat_t m);
        for (int i = 0; i < MM_DIM * MM_DIM; i++) begin
            rnd_state = lcg_next(rnd_state);
            m[i] = rnd_state;
        end
    endtask

    // A first, then B, both row-major
    task automatic send_matrices(input mat_t a, input mat_t b);
        int idx;
        idx = 0;
        while (idx < 32) begin
            rnd_state = lcg_next(rnd_state);
            if (gaps_on && rnd_state[17:16] == 2'b00) begin
                ss_tvalid = 1'b0;
            end else begin
                ss_tvalid = 1'b1;
                ss_tdata  = (idx < 16) ? a[idx] : b[idx - 16];
            end
            @(negedge axis_clk);
            if (ss_tvalid && ss_tready) begin
                idx++;
                in_beats++;
            end
            @(posedge axis_clk);
            #0.5;
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic run_job(input mat_t a, input mat_t b, input mat_t expected);
        for (int i = 0; i < MM_DIM * MM_DIM; i++) begin
            exp_q.push_back(expected[i]);
        end
        send_matrices(a, b);
    endtask

    // a few idle cycles catch any extra output beat
    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge axis_clk);
        end
        repeat (4) @(posedge axis_clk);
        #0.5;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d %s: ok", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: FAILED with %0d errors", num, name, err_cnt - errs_before);
        end
    endtask

    always @(posedge axis_clk) begin
        #0.5;
        if (stall_on) begin
            rdy_state = lcg_next(rdy_state);
            sm_tready = (rdy_state[17:16] != 2'b00);
        end else begin
            sm_tready = 1'b1;
        end
    end

    // outputs are stable at the falling edge, so sample there
    always @(negedge axis_clk) begin
        if (axis_rst_n && sm_tvalid) begin
            if (in_beats < 32 * (out_beats / 16 + 1)) begin
                $display("at %0t ns: sm_tvalid is high before all 32 input beats of the job",
                         $time);
                err_cnt++;
            end
            if (sm_tready) begin
                if (exp_q.size() == 0) begin
                    $display("at %0t ns: output beat %0d arrived with no word expected",
                             $time, out_beats);
                    err_cnt++;
                end else begin
                    exp_word = exp_q.pop_front();
                    check_val("sm_tdata", sm_tdata, exp_word);
                end
                out_beats++;
            end
        end
    end

    always @(posedge axis_clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        mat_t a;
        mat_t b;
        int   errs;
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        gaps_on    = 1'b0;
        stall_on   = 1'b0;
        rnd_state  = 32'd98;
        rdy_state  = 32'd98;
        in_beats   = 0;
        out_beats  = 0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        cycles     = 0;

        repeat (16) @(posedge axis_clk);
        #0.5;
        axis_rst_n = 1'b1;

        errs = err_cnt;
        @(negedge axis_clk);
        check_val("ss_tready", 32'(ss_tready), 32'd0);
        check_val("sm_tvalid", 32'(sm_tvalid), 32'd0);
        // one idle cycle, then the load phase
        @(negedge axis_clk);
        check_val("ss_tready", 32'(ss_tready), 32'd1);
        check_val("sm_tvalid", 32'(sm_tvalid), 32'd0);
        @(posedge axis_clk);
        #0.5;
        report_test(1, "reset", errs);

        errs = err_cnt;
        for (int i = 0; i < MM_DIM * MM_DIM; i++) begin
            a[i] = (i / MM_DIM == i % MM_DIM) ? 32'd1 : 32'd0;
        end
        fill_random(b);
        run_job(a, b, b);
        wait_drained();
        report_test(2, "identity", errs);

        errs = err_cnt;
        fill_random(a);
        fill_random(b);
        a[0] = 32'hffff_ffff;
        b[0] = 32'hffff_ffff;
        run_job(a, b, matmul_ref(a, b));
        wait_drained();
        report_test(3, "random wrap", errs);

        errs = err_cnt;
        gaps_on = 1'b1;
        fill_random(a);
        fill_random(b);
        run_job(a, b, matmul_ref(a, b));
        wait_drained();
        gaps_on = 1'b0;
        report_test(4, "input gaps", errs);

        errs = err_cnt;
        stall_on = 1'b1;
        fill_random(a);
        fill_random(b);
        run_job(a, b, matmul_ref(a, b));
        wait_drained();
        stall_on = 1'b0;
        report_test(5, "output stalls", errs);

        errs = err_cnt;
        for (int j = 0; j < 3; j++) begin
            fill_random(a);
            fill_random(b);
            run_job(a, b, matmul_ref(a, b));
        end
        wait_drained();
        report_test(6, "back to back", errs);

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verilog/mm_ctrl.sv
`timescale 1ns/1ps

module mm_ctrl (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  load_done,
    input  logic                  drain_done,
    output logic                  ss_tready,
    output logic                  clear,
    output logic                  step_en,
    output logic                  drain_start,
    output mm_data_pkg::mm_step_t step
);
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    mm_state_e state;
    mm_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                state_nxt = ST_LOAD;
            end
            ST_LOAD: begin
                if (load_done) begin
                    state_nxt = ST_CALC;
                end
            end
            ST_CALC: begin
                if (drain_start) begin
                    state_nxt = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (drain_done) begin
                    state_nxt = ST_LOAD;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state <= ST_IDLE;
            step  <= '0;
            clear <= 1'b0;
        end else begin
            state <= state_nxt;
            // high in the first load cycle of every job
            clear <= (state != ST_LOAD) && (state_nxt == ST_LOAD);
            if (step_en) begin
                step <= step + 1'b1;
            end
        end
    end

    assign ss_tready   = (state == ST_LOAD);
    assign step_en     = (state == ST_CALC);
    assign drain_start = step_en && (step == mm_step_t'(MM_CALC_STEPS - 1));

endmodule

// File: verilog/mm_ctrl_pkg.sv
package mm_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_CALC,
        ST_DRAIN
    } mm_state_e;

    // A and B together
    localparam int MM_LOAD_BEATS = 32;
    localparam int MM_CALC_STEPS = 16;
    localparam int MM_OUT_BEATS  = 16;

endpackage

// File: verilog/mm_data_pkg.sv
package mm_data_pkg;

    localparam int MM_WORD_W = 32;
    localparam int MM_DIM    = 4;

    typedef logic [MM_WORD_W-1:0]                   mm_word_t;
    typedef logic [$clog2(MM_DIM)-1:0]              mm_idx_t;
    // one extra bit so a full matrix count of 16 fits
    typedef logic [$clog2(MM_DIM*MM_DIM):0]         mm_beat_cnt_t;
    // upper half is the phase, lower half the inner index
    typedef logic [$clog2(MM_DIM*MM_DIM)-1:0]       mm_step_t;

    typedef struct packed {
        logic     valid;
        logic     sel_b;
        mm_idx_t  row;
        mm_idx_t  col;
        mm_word_t data;
    } mm_wr_t;

    typedef struct packed {
        mm_word_t [MM_DIM-1:0] a;
        mm_word_t [MM_DIM-1:0] b;
    } mm_lane_ops_t;

endpackage

// File: verilog/mm_drain.sv
`timescale 1ns/1ps

module mm_drain (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  drain_start,
    output mm_data_pkg::mm_idx_t  rd_row,
    output mm_data_pkg::mm_idx_t  rd_col,
    input  mm_data_pkg::mm_word_t rd_data,
    output logic                  sm_tvalid,
    input  logic                  sm_tready,
    output mm_data_pkg::mm_word_t sm_tdata,
    output logic                  drain_done
);
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    // index of the word to fetch on the next accepted beat
    mm_beat_cnt_t nxt;
    logic         accept;

    assign accept     = sm_tvalid && sm_tready;
    assign drain_done = accept && (nxt == mm_beat_cnt_t'(MM_OUT_BEATS));

    assign rd_row = nxt[3:2];
    assign rd_col = nxt[1:0];

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            nxt       <= '0;
        end else if (drain_start) begin
            sm_tvalid <= 1'b1;
            nxt       <= nxt + 1'b1;
        end else if (drain_done) begin
            sm_tvalid <= 1'b0;
            nxt       <= '0;
        end else if (accept) begin
            nxt <= nxt + 1'b1;
        end
    end

    // C[0][0] is final a whole phase before the last step
    always_ff @(posedge axis_clk) begin
        if (drain_start || (accept && !drain_done)) begin
            sm_tdata <= rd_data;
        end
    end

endmodule

// File: verilog/mm_loader.sv
`timescale 1ns/1ps

module mm_loader (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  ss_tvalid,
    input  logic                  ss_tready,
    input  mm_data_pkg::mm_word_t ss_tdata,
    output mm_data_pkg::mm_wr_t   wr,
    output logic                  load_done
);
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    mm_beat_cnt_t a_cnt;
    mm_beat_cnt_t b_cnt;
    mm_beat_cnt_t cur;
    logic         accept;
    logic         a_full;

    assign accept = ss_tvalid && ss_tready;

    // half of the load phase belongs to each matrix
    assign a_full = (a_cnt == mm_beat_cnt_t'(MM_LOAD_BEATS / 2));
    assign cur    = a_full ? b_cnt : a_cnt;

    assign load_done = accept && a_full &&
                       (b_cnt == mm_beat_cnt_t'(MM_LOAD_BEATS / 2 - 1));

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            a_cnt <= '0;
            b_cnt <= '0;
        end else if (load_done) begin
            a_cnt <= '0;
            b_cnt <= '0;
        end else if (accept) begin
            if (a_full) begin
                b_cnt <= b_cnt + 1'b1;
            end else begin
                a_cnt <= a_cnt + 1'b1;
            end
        end
    end

    // row-major beat order, so the count splits into row and column
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr <= '0;
        end else begin
            wr.valid <= accept;
            wr.sel_b <= a_full;
            wr.row   <= cur[3:2];
            wr.col   <= cur[1:0];
            wr.data  <= ss_tdata;
        end
    end

endmodule

// File: verilog/mm_mac_array.sv
`timescale 1ns/1ps

module mm_mac_array (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  logic                      clear,
    input  logic                      step_en,
    input  mm_data_pkg::mm_step_t     step,
    input  mm_data_pkg::mm_lane_ops_t ops,
    input  mm_data_pkg::mm_idx_t      rd_row,
    input  mm_data_pkg::mm_idx_t      rd_col,
    output mm_data_pkg::mm_word_t     rd_data
);
    import mm_data_pkg::*;

    mm_word_t c_reg   [MM_DIM][MM_DIM];
    mm_word_t prod    [MM_DIM];
    mm_idx_t  acc_col [MM_DIM];

    // products wrap to the word width
    always_comb begin
        for (int k = 0; k < MM_DIM; k++) begin
            prod[k]    = ops.a[k] * ops.b[k];
            acc_col[k] = mm_idx_t'(k) + step[3:2];
        end
    end

    // lane k owns row k, the column moves on with each phase
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n || clear) begin
            for (int r = 0; r < MM_DIM; r++) begin
                for (int c = 0; c < MM_DIM; c++) begin
                    c_reg[r][c] <= '0;
                end
            end
        end else if (step_en) begin
            for (int k = 0; k < MM_DIM; k++) begin
                c_reg[k][acc_col[k]] <= c_reg[k][acc_col[k]] + prod[k];
            end
        end
    end

    assign rd_data = c_reg[rd_row][rd_col];

endmodule

// File: verilog/mm_rotate_store.sv
`timescale 1ns/1ps

module mm_rotate_store (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  mm_data_pkg::mm_wr_t       wr,
    input  logic                      step_en,
    input  mm_data_pkg::mm_step_t     step,
    output mm_data_pkg::mm_lane_ops_t ops
);
    import mm_data_pkg::*;

    // a lane k holds row k of A, b lane k holds the column it works on
    mm_word_t a_lane [MM_DIM][MM_DIM];
    mm_word_t b_lane [MM_DIM][MM_DIM];

    mm_idx_t  wr_lane;
    mm_idx_t  wr_pos;
    logic     shift_b;

    assign wr_lane = wr.sel_b ? wr.col : wr.row;

    // the last B word arrives together with step 0 and lands one place
    // back, where the rotation would have moved it
    assign wr_pos = (wr.sel_b ? wr.row : wr.col) - mm_idx_t'(step_en);

    // end of a phase, hand each column to the next lane down
    assign shift_b = (step[1:0] == mm_idx_t'(MM_DIM - 1));

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            for (int k = 0; k < MM_DIM; k++) begin
                for (int i = 0; i < MM_DIM; i++) begin
                    a_lane[k][i] <= '0;
                    b_lane[k][i] <= '0;
                end
            end
        end else begin
            if (step_en) begin
                for (int k = 0; k < MM_DIM; k++) begin
                    for (int i = 0; i < MM_DIM; i++) begin
                        a_lane[k][i] <= a_lane[k][(i + 1) % MM_DIM];
                        b_lane[k][i] <= b_lane[shift_b ? (k + 1) % MM_DIM : k]
                                              [(i + 1) % MM_DIM];
                    end
                end
            end
            if (wr.valid) begin
                if (wr.sel_b) begin
                    b_lane[wr_lane][wr_pos] <= wr.data;
                end else begin
                    a_lane[wr_lane][wr_pos] <= wr.data;
                end
            end
        end
    end

    // lane heads feed the MACs
    always_comb begin
        for (int k = 0; k < MM_DIM; k++) begin
            ops.a[k] = a_lane[k][0];
            ops.b[k] = b_lane[k][0];
        end
    end

endmodule

// File: verilog/mm_top.sv
`timescale 1ns/1ps

module mm_top (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  ss_tvalid,
    output logic                  ss_tready,
    input  mm_data_pkg::mm_word_t ss_tdata,
    output logic                  sm_tvalid,
    input  logic                  sm_tready,
    output mm_data_pkg::mm_word_t sm_tdata
);
    import mm_data_pkg::*;

    mm_wr_t       wr;
    mm_lane_ops_t ops;
    mm_step_t     step;
    mm_idx_t      rd_row;
    mm_idx_t      rd_col;
    mm_word_t     rd_data;
    logic         load_done;
    logic         drain_done;
    logic         clear;
    logic         step_en;
    logic         drain_start;

    mm_loader u_loader (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .wr         (wr),
        .load_done  (load_done)
    );

    mm_rotate_store u_store (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .wr         (wr),
        .step_en    (step_en),
        .step       (step),
        .ops        (ops)
    );

    mm_mac_array u_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .clear      (clear),
        .step_en    (step_en),
        .step       (step),
        .ops        (ops),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .rd_data    (rd_data)
    );

    mm_ctrl u_ctrl (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .load_done   (load_done),
        .drain_done  (drain_done),
        .ss_tready   (ss_tready),
        .clear       (clear),
        .step_en     (step_en),
        .drain_start (drain_start),
        .step        (step)
    );

    mm_drain u_drain (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .drain_start (drain_start),
        .rd_row      (rd_row),
        .rd_col      (rd_col),
        .rd_data     (rd_data),
        .sm_tvalid   (sm_tvalid),
        .sm_tready   (sm_tready),
        .sm_tdata    (sm_tdata),
        .drain_done  (drain_done)
    );

endmodule
